//--- rtl/ntt_pkg.sv
/*
  pointwise multiplier shared definitions
  ring and bank geometry, modulus and Barrett constants, phase encoding
*/
package ntt_pkg;

    // coefficient arithmetic
    localparam int coef_width = 14;
    localparam logic [coef_width-1:0] modulus_q = 14'd12289;  // ntt friendly prime

    // Barrett reduction, m = floor(2^k / q)
    localparam int barrett_k = 28;
    localparam logic [coef_width:0] barrett_m = 15'd21843;

    // lane and bank geometry
    localparam int pe_number  = 4;                      // multiplier lanes
    localparam int bank_count = 2 * pe_number;          // even + odd bank per lane
    localparam int ring_size  = 64;                     // coefficients per polynomial
    localparam int bank_depth = ring_size / bank_count; // rows per bank
    localparam int addr_width = $clog2(bank_depth);

    // pipeline timing
    localparam int mul_delay    = 3;                           // mod_mul latency
    localparam int done_latency = 2 * bank_depth + mul_delay + 2;

    // multiply phase runs reads of both halves plus the pipeline drain
    localparam int mul_cycles = 2 * bank_depth + mul_delay;
    localparam int cnt_width  = $clog2(mul_cycles);

    typedef logic [coef_width-1:0] coef_t;
    typedef logic [addr_width-1:0] addr_t;

    // controller phases
    typedef enum logic [1:0] {
        phase_idle = 2'd0,
        phase_load = 2'd1,  // rows come in on bank_in
        phase_mul  = 2'd2,  // secret key multiply, write back in place
        phase_out  = 2'd3   // rows stream out
    } phase_t;

endpackage

//--- rtl/coef_bank.sv
/*
  coefficient bank
  one write port, one registered read port, bank_depth words
*/
`timescale 1ns/1ps

module coef_bank (
    input  logic           clk,
    input  logic           wr_en,
    input  ntt_pkg::addr_t wr_addr,
    input  ntt_pkg::coef_t wr_data,
    input  ntt_pkg::addr_t rd_addr,
    output ntt_pkg::coef_t rd_data
);
    import ntt_pkg::*;

    coef_t mem [bank_depth];  // maps to distributed or block ram

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data one cycle after address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/mod_mul.sv
/*
  modular multiplier, p = a * b mod q
  three stage pipeline with Barrett reduction
*/
`timescale 1ns/1ps

module mod_mul (
    input  logic           clk,
    input  logic           reset,
    input  ntt_pkg::coef_t a,
    input  ntt_pkg::coef_t b,
    output ntt_pkg::coef_t p
);
    import ntt_pkg::*;

    // stage 1, full product below q^2
    logic [2*coef_width-1:0] prod_q;

    // stage 2, quotient estimate next to the product
    logic [3*coef_width:0]   est_full;  // prod * m, 43 bits
    logic [coef_width:0]     quot_q;
    logic [2*coef_width-1:0] prod_d_q;

    // stage 3 combinational part
    logic [2*coef_width-1:0] quot_times_q;
    logic [2*coef_width-1:0] diff_full;
    logic [coef_width+1:0]   r0;  // below 3q, fits 16 bits
    logic [coef_width+1:0]   r1;
    logic [coef_width+1:0]   r2;

    assign est_full = prod_q * barrett_m;

    assign quot_times_q = quot_q * modulus_q;
    assign diff_full    = prod_d_q - quot_times_q;
    assign r0           = diff_full[coef_width+1:0];

    // estimate is short by at most two multiples of q
    assign r1 = (r0 >= modulus_q) ? r0 - modulus_q : r0;
    assign r2 = (r1 >= modulus_q) ? r1 - modulus_q : r1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_q   <= '0;
            quot_q   <= '0;
            prod_d_q <= '0;
            p        <= '0;
        end else begin
            prod_q   <= a * b;
            quot_q   <= est_full[barrett_k +: coef_width+1];  // >> k
            prod_d_q <= prod_q;
            p        <= r2[coef_width-1:0];
        end
    end

endmodule

//--- rtl/pointwise_ctrl.sv
/*
  pointwise multiply controller
  phase FSM and cycle counter, bank read and write addressing,
  write-back delay line matching bank and multiplier latency, done pulse
*/
`timescale 1ns/1ps

module pointwise_ctrl (
    input  logic            clk,
    input  logic            reset,
    input  logic            load_bram,
    input  logic            start,
    output ntt_pkg::phase_t phase,
    output ntt_pkg::addr_t  rd_addr,
    output ntt_pkg::addr_t  wr_addr,
    output logic            wr_en,
    output logic            rd_bank_sel,
    output logic            wr_bank_sel,
    output logic            done
);
    import ntt_pkg::*;

    localparam int dl_depth = mul_delay + 1;  // bank read + multiplier

    logic [cnt_width-1:0] cnt;  // cycle within phase

    logic  rd_valid;            // multiply phase read issued this cycle
    logic  rd_sel;              // 0 even banks, 1 odd banks

    // write-back delay line, stage 0 lines up with bank read data
    logic [dl_depth-1:0] dl_valid;
    logic [dl_depth-1:0] dl_sel;
    addr_t               dl_addr [dl_depth];

    // phase FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= phase_idle;
            cnt   <= '0;
        end else begin
            case (phase)
                phase_idle: begin
                    cnt <= '0;
                    if (load_bram) begin
                        phase <= phase_load;
                    end else if (start) begin
                        phase <= phase_mul;
                    end
                end
                phase_load: begin  // one row per cycle
                    if (cnt == cnt_width'(bank_depth - 1)) begin
                        phase <= phase_idle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                phase_mul: begin
                    // even half, odd half, then drain the lanes
                    if (cnt == cnt_width'(mul_cycles - 1)) begin
                        phase <= phase_out;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                phase_out: begin
                    if (cnt == cnt_width'(bank_depth - 1)) begin
                        phase <= phase_idle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    phase <= phase_idle;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // row index is the low counter bits in every phase
    assign rd_addr  = cnt[addr_width-1:0];
    assign rd_sel   = cnt[addr_width];  // second half of reads go odd
    assign rd_valid = (phase == phase_mul) && (cnt < cnt_width'(2 * bank_depth));

    // valid and select shift, cleared on reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dl_valid <= '0;
            dl_sel   <= '0;
        end else begin
            dl_valid <= {dl_valid[dl_depth-2:0], rd_valid};
            dl_sel   <= {dl_sel[dl_depth-2:0], rd_sel};
        end
    end

    // address follows the same path
    always_ff @(posedge clk) begin
        dl_addr[0] <= rd_addr;
        for (int i = 1; i < dl_depth; i++) begin
            dl_addr[i] <= dl_addr[i-1];
        end
    end

    assign rd_bank_sel = dl_sel[0];  // select for data leaving the banks now

    // load writes straight from the counter, otherwise delayed write-back
    assign wr_en       = (phase == phase_load) || dl_valid[dl_depth-1];
    assign wr_addr     = (phase == phase_load) ? cnt[addr_width-1:0] : dl_addr[dl_depth-1];
    assign wr_bank_sel = dl_sel[dl_depth-1];

    // done one cycle into the output phase, row 0 already read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= (phase == phase_out) && (cnt == '0);
        end
    end

endmodule

//--- rtl/pointwise_mul_top.sv
/*
  pointwise secret key multiplier
  loads one polynomial into 2*pe_number banks, multiplies every
  coefficient by its lane key mod q in place, then streams all rows out
*/
`timescale 1ns/1ps

module pointwise_mul_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     load_bram,
    input  logic                                     start,
    input  ntt_pkg::coef_t [ntt_pkg::bank_count-1:0] bank_in,
    input  ntt_pkg::coef_t [ntt_pkg::pe_number-1:0]  secret_key,
    output logic                                     done,
    output ntt_pkg::coef_t [ntt_pkg::bank_count-1:0] bank_out
);
    import ntt_pkg::*;

    phase_t phase;
    addr_t  rd_addr;
    addr_t  wr_addr;
    logic   wr_en;
    logic   rd_bank_sel;
    logic   wr_bank_sel;

    logic [bank_count-1:0] bank_we;
    coef_t                 bank_wd [bank_count];
    coef_t                 bank_rd [bank_count];

    coef_t lane_a [pe_number];  // coefficient operand per lane
    coef_t lane_p [pe_number];  // reduced product per lane

    logic row_valid;  // bank read data is an output row

    pointwise_ctrl ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .load_bram   (load_bram),
        .start       (start),
        .phase       (phase),
        .rd_addr     (rd_addr),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .rd_bank_sel (rd_bank_sel),
        .wr_bank_sel (wr_bank_sel),
        .done        (done)
    );

    for (genvar b = 0; b < bank_count; b++) begin : g_bank
        // all banks during load, else only the half being written back
        assign bank_we[b] = (phase == phase_load) ? wr_en
                          : (wr_en && (wr_bank_sel == 1'(b % 2)));
        assign bank_wd[b] = (phase == phase_load) ? bank_in[b] : lane_p[b/2];

        coef_bank bank_inst (
            .clk     (clk),
            .wr_en   (bank_we[b]),
            .wr_addr (wr_addr),
            .wr_data (bank_wd[b]),
            .rd_addr (rd_addr),
            .rd_data (bank_rd[b])
        );
    end

    for (genvar k = 0; k < pe_number; k++) begin : g_lane
        assign lane_a[k] = rd_bank_sel ? bank_rd[2*k+1] : bank_rd[2*k];  // even then odd

        mod_mul mul_inst (
            .clk   (clk),
            .reset (reset),
            .a     (lane_a[k]),
            .b     (secret_key[k]),  // held by the host during the run
            .p     (lane_p[k])
        );
    end

    // output register, zero outside the row stream
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_valid <= 1'b0;
            bank_out  <= '0;
        end else begin
            row_valid <= (phase == phase_out);  // one cycle bank latency
            for (int b = 0; b < bank_count; b++) begin
                bank_out[b] <= row_valid ? bank_rd[b] : '0;
            end
        end
    end

endmodule

//--- verification/tb_pointwise_mul.sv
/*
  testbench for the pointwise secret key multiplier
  LFSR driven loads and keys checked against a mod q model
*/
`timescale 1ns/1ps

module tb_pointwise_mul;
    import ntt_pkg::*;

    localparam logic [31:0] lfsr_seed  = 32'he3aed703;
    localparam logic [31:0] lfsr_taps  = 32'hb4bcd35c;  // galois feedback mask
    localparam int          wait_limit = 4 * done_latency;
    localparam int          q_int      = int'(modulus_q);

    logic                   clk;
    logic                   reset;
    logic                   load_bram;
    logic                   start;
    coef_t [bank_count-1:0] bank_in;
    coef_t [pe_number-1:0]  secret_key;
    logic                   done;
    coef_t [bank_count-1:0] bank_out;

    logic [31:0] lfsr_state;
    int          model [bank_count][bank_depth];  // expected bank contents
    int          key_val [pe_number];
    int          check_count;
    int          error_count;
    int          test_checks;  // counters at the start of a test
    int          test_errors;
    bit          timed_out;
    string       timeout_msg;

    pointwise_mul_top pointwise_mul_top_inst (
        .clk        (clk),
        .reset      (reset),
        .load_bram  (load_bram),
        .start      (start),
        .bank_in    (bank_in),
        .secret_key (secret_key),
        .done       (done),
        .bank_out   (bank_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one lfsr step per bit with the msb first
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // 14 random bits folded once below q
    function automatic int rand_coef();
        int v;
        v = int'(take_bits(coef_width));
        if (v >= q_int) begin
            v = v - q_int;
        end
        return v;
    endfunction

    // four state compare so x or z on an output counts as a mismatch
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s, got %0d expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_bus_zero(input string what);
        for (int b = 0; b < bank_count; b++) begin
            check_value(32'(bank_out[b]), 0, $sformatf("%s, bank %0d", what, b));
        end
    endtask

    task automatic begin_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
    endtask

    task automatic fill_random();
        for (int b = 0; b < bank_count; b++) begin
            for (int r = 0; r < bank_depth; r++) begin
                model[b][r] = rand_coef();
            end
        end
    endtask

    task automatic random_keys();
        for (int k = 0; k < pe_number; k++) begin
            key_val[k] = rand_coef();
        end
    endtask

    // load strobe followed by one row per cycle
    task automatic load_model();
        @(negedge clk);
        load_bram = 1'b1;
        for (int r = 0; r < bank_depth; r++) begin
            @(negedge clk);
            load_bram = 1'b0;
            for (int b = 0; b < bank_count; b++) begin
                bank_in[b] = coef_t'(model[b][r]);
            end
        end
        @(negedge clk);
        bank_in = '0;
    endtask

    // starts a run and checks the done latency and the row stream
    task automatic run_multiply(input bit strobe_during_output);
        int   waited;
        logic got_done;
        @(negedge clk);
        for (int k = 0; k < pe_number; k++) begin
            secret_key[k] = coef_t'(key_val[k]);  // held until the next run
        end
        start    = 1'b1;
        waited   = 0;
        got_done = 1'b0;
        while (!got_done && waited < wait_limit) begin
            @(negedge clk);
            start    = 1'b0;
            waited++;
            got_done = done;
        end
        if (!got_done) begin
            timed_out   = 1'b1;
            timeout_msg = $sformatf("done did not arrive within %0d cycles of start", wait_limit);
            return;
        end
        check_value(waited, done_latency, "start to done latency");
        check_bus_zero("bank_out in the done cycle");

        // in place product where lane k owns banks 2k and 2k+1
        for (int b = 0; b < bank_count; b++) begin
            for (int r = 0; r < bank_depth; r++) begin
                model[b][r] = int'((longint'(model[b][r]) * longint'(key_val[b/2]))
                                   % longint'(q_int));
            end
        end

        for (int r = 0; r < bank_depth; r++) begin
            @(negedge clk);
            start = strobe_during_output && (r == bank_depth / 2);  // mid stream
            for (int b = 0; b < bank_count; b++) begin
                check_value(32'(bank_out[b]), model[b][r], $sformatf("row %0d bank %0d", r, b));
            end
        end
        @(negedge clk);
        start = 1'b0;
        check_bus_zero("bank_out after the last row");
    endtask

    task automatic idle_after_reset();
        begin_test();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value(32'(done), 0, "done while idle");
            check_bus_zero("bank_out while idle");
        end
        end_test("test 1 idle after reset");
    endtask

    task automatic random_multiply();
        begin_test();
        fill_random();
        load_model();
        random_keys();
        run_multiply(1'b0);
        if (timed_out) return;
        end_test("test 2 random load and multiply");
    endtask

    task automatic edge_key_multiply();
        begin_test();
        fill_random();
        for (int b = 0; b < bank_count; b++) begin
            model[b][0] = q_int - 1;  // largest coefficient
            model[b][1] = 0;
        end
        load_model();
        key_val[0] = 1;          // identity
        key_val[1] = 0;          // clears both banks
        key_val[2] = q_int - 1;  // negation mod q
        key_val[3] = rand_coef();
        run_multiply(1'b0);
        if (timed_out) return;
        end_test("test 3 edge keys");
    endtask

    task automatic ignored_start();
        begin_test();
        fill_random();
        load_model();
        random_keys();
        run_multiply(1'b1);  // extra start pulse while rows stream out
        if (timed_out) return;
        for (int i = 0; i < done_latency + bank_depth; i++) begin
            @(negedge clk);
            check_value(32'(done), 0, "done after a start in the output phase");
            check_bus_zero("bank_out after an ignored start");
        end
        end_test("test 4 output framing and ignored start");
    endtask

    // banks keep the last products with no reload in between
    task automatic chained_multiply();
        begin_test();
        for (int n = 0; n < 2; n++) begin
            random_keys();
            run_multiply(1'b0);
            if (timed_out) return;
        end
        end_test("test 5 chained multiply without reload");
    endtask

    initial begin
        lfsr_state  = lfsr_seed;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        timeout_msg = "";
        reset       = 1'b1;
        load_bram   = 1'b0;
        start       = 1'b0;
        bank_in     = '0;
        secret_key  = '0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        idle_after_reset();
        if (!timed_out) random_multiply();
        if (!timed_out) edge_key_multiply();
        if (!timed_out) ignored_start();
        if (!timed_out) chained_multiply();

        if (timed_out) begin
            $display("timeout: %s", timeout_msg);
        end
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (!timed_out && error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/ntt_pkg.sv
rtl/coef_bank.sv
rtl/mod_mul.sv
rtl/pointwise_ctrl.sv
rtl/pointwise_mul_top.sv
verification/tb_pointwise_mul.sv

//--- Makefile
# Verilator flow for the pointwise secret key multiplier

VERILATOR ?= verilator
VFLAGS    ?= --sv --timing
TOP       ?= tb_pointwise_mul
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the pass line in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
